// ==== bench/i2c_patterns.txt ====
# name op prescale(hex) addr(hex) count(dec) d0 d1 d2 d3 (hex)
# status compares with d0, nack programs the DUT with d0 as a wrong address
after_reset  status 00 00 0 50 00 00 00
regs_rw      regs   05 2a 0 00 00 00 00
write_one    write  01 50 1 a5 00 00 00
write_four   write  02 3c 4 01 80 ff 5a
read_two     read   01 48 2 c3 3e 00 00
read_four    read   03 11 4 00 ff 81 7e
tx_full      full   01 61 9 00 00 00 00
nack_addr    nack   01 22 1 23 00 00 00

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic pclk,
    output logic presetn
);

    // 100 ns period
    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    // Held for two cycles, released on a falling edge
    initial begin
        presetn = 1'b0;
        repeat (2) @(posedge pclk);
        @(negedge pclk);
        presetn = 1'b1;
    end

endmodule

// ==== bench/tb_i2c_apb.sv ====
`timescale 1ns/1ps
`include "i2c_params.svh"

module tb_i2c_apb;

    localparam logic [7:0] ST_TX_FULL  = 8'h80;
    localparam logic [7:0] ST_RX_EMPTY = 8'h10;
    localparam logic [7:0] ST_NACK     = 8'h04;
    localparam logic [7:0] ST_IDLE     = 8'h50;  // Both FIFOs empty

    logic       pclk;
    logic       presetn;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    logic [7:0] pwdata;
    logic       pready;
    logic [7:0] prdata;
    logic       scl_oe;
    logic       sda_oe;
    logic       slave_pull;  // Slave model holds SDA low
    wire        scl_line;
    wire        sda_line;

    // Pull-ups on both lines, wired AND on SDA
    assign scl_line = !scl_oe;
    assign sda_line = !sda_oe && !slave_pull;

    string      rec_name [32];
    string      rec_op   [32];
    logic [7:0] rec_pre  [32];
    logic [7:0] rec_addr [32];
    int         rec_cnt  [32];
    logic [7:0] rec_data [32][4];
    int         n_recs;
    string      cur_name;
    int         errors;
    int         pass_cnt;
    int         fail_cnt;
    int         cycles;
    int         cycle_limit = 1000;

    // Slave model state
    logic [6:0] slave_addr;
    logic [7:0] slave_rd [16];
    logic [7:0] captured [$];
    logic [7:0] addr_seen;
    logic [7:0] rx_shift;
    int         bit_n;       // -1 until the SCL fall after a start
    int         byte_n;
    int         scl_rises;
    logic       in_frame;
    logic       is_read;
    logic       addr_ok;
    logic       master_ack;

    tb_clock clk_gen (.pclk(pclk), .presetn(presetn));

    i2c_apb_top i2c_apb_top_i (
        .PCLK    (pclk),
        .PRESETn (presetn),
        .PSELx   (psel),
        .PENABLE (penable),
        .PWRITE  (pwrite),
        .PADDR   (paddr),
        .PWDATA  (pwdata),
        .PREADY  (pready),
        .PRDATA  (prdata),
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe),
        .sda_in  (sda_line)
    );

    always @(posedge pclk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run timed out, engine never went idle");
            $display("Regression failed");
            $finish;
        end
    end

    always @(negedge sda_line) begin
        if (scl_line) begin  // Start condition
            in_frame = 1'b1;
            bit_n    = -1;
            byte_n   = 0;
        end
    end

    always @(posedge sda_line) begin
        if (scl_line)
            in_frame = 1'b0;  // Stop condition
    end

    always @(posedge scl_line) begin
        scl_rises = scl_rises + 1;
        if (in_frame && bit_n >= 0 && bit_n < 8)
            rx_shift = {rx_shift[6:0], sda_line};
        else if (in_frame && bit_n == 8)
            master_ack = !sda_line;
    end

    // Slave changes SDA only after SCL falls
    always @(negedge scl_line) begin
        if (in_frame) begin
            if (bit_n < 0) begin
                bit_n = 0;
            end else if (bit_n < 7) begin
                bit_n = bit_n + 1;
                if (is_read && byte_n > 0)
                    slave_pull = !slave_rd[byte_n-1][7-bit_n];
            end else if (bit_n == 7) begin
                bit_n = 8;
                if (byte_n == 0) begin
                    addr_seen  = rx_shift;
                    is_read    = rx_shift[0];
                    addr_ok    = (rx_shift[7:1] == slave_addr);
                    slave_pull = addr_ok;
                end else if (!is_read) begin
                    captured.push_back(rx_shift);
                    slave_pull = 1'b1;
                end else begin
                    slave_pull = 1'b0;  // Master acknowledges
                end
            end else begin
                bit_n      = 0;
                slave_pull = 1'b0;
                if (!addr_ok)
                    in_frame = 1'b0;
                else if (is_read && (byte_n == 0 || master_ack))
                    slave_pull = !slave_rd[byte_n][7];
                byte_n = byte_n + 1;
            end
        end
    end

    task automatic report_mismatch(input string what, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("Mismatch in %s, %s: expected %h, actual %h", cur_name, what, exp, act);
        errors = errors + 1;
    endtask

    task automatic apb_access(input logic wr, input logic [2:0] sel,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = {sel, 5'b0};
        pwdata  = wdata;
        @(negedge pclk);
        penable = 1'b1;
        #20;  // Mid low phase
        rdata = prdata;
        if (pready !== 1'b1) begin
            $display("Test %s: PREADY was low in an access phase", cur_name);
            errors = errors + 1;
        end
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [2:0] sel, input logic [7:0] data);
        logic [7:0] unused_rd;
        apb_access(1'b1, sel, data, unused_rd);
    endtask

    task automatic apb_read(input logic [2:0] sel, output logic [7:0] data);
        apb_access(1'b0, sel, 8'h00, data);
    endtask

    task automatic setup_transfer(input int idx, input logic [7:0] dut_addr);
        apb_write(`I2C_SEL_PRESCALE, rec_pre[idx]);
        apb_write(`I2C_SEL_ADDR, dut_addr);
        slave_addr = rec_addr[idx][6:0];
        for (int k = 0; k < 4; k++)
            slave_rd[k] = rec_data[idx][k];
        captured.delete();
        scl_rises  = 0;
        slave_pull = 1'b0;
    endtask

    // Go, then poll status until busy drops
    task automatic start_transfer(input logic [7:0] cmd, output logic [7:0] st);
        apb_write(`I2C_SEL_CMD, cmd);
        apb_read(`I2C_SEL_STATUS, st);
        if (st[3] !== 1'b1) begin
            $display("Test %s: busy did not rise after go", cur_name);
            errors = errors + 1;
        end
        while (st[3] === 1'b1)
            apb_read(`I2C_SEL_STATUS, st);
    endtask

    task automatic run_write(input int idx);
        logic [7:0] sent [$];
        logic [7:0] b;
        logic [7:0] st;
        logic       fill;
        int         n_push;
        fill   = (rec_op[idx] == "full");
        n_push = fill ? `I2C_FIFO_DEPTH + 1 : rec_cnt[idx];
        setup_transfer(idx, rec_addr[idx]);
        for (int k = 0; k < n_push; k++) begin
            b = fill ? 8'($urandom) : rec_data[idx][k % 4];
            apb_write(`I2C_SEL_TX, b);
            if (k < `I2C_FIFO_DEPTH)
                sent.push_back(b);  // Later bytes hit a full FIFO
        end
        if (fill) begin
            apb_read(`I2C_SEL_STATUS, st);
            if (st !== (ST_TX_FULL | ST_RX_EMPTY))
                report_mismatch("status when full", ST_TX_FULL | ST_RX_EMPTY, st);
        end
        start_transfer(8'h80, st);
        if (st !== ST_IDLE)
            report_mismatch("final status", ST_IDLE, st);
        if (addr_seen !== {rec_addr[idx][6:0], 1'b0})
            report_mismatch("address byte", {rec_addr[idx][6:0], 1'b0}, addr_seen);
        if (scl_rises != 9 * (sent.size() + 1) + 1)
            report_mismatch("SCL pulses", 9 * (sent.size() + 1) + 1, scl_rises);
        if (captured.size() != sent.size())
            report_mismatch("byte count", sent.size(), captured.size());
        else
            for (int k = 0; k < sent.size(); k++)
                if (captured[k] !== sent[k])
                    report_mismatch($sformatf("byte %0d", k), sent[k], captured[k]);
    endtask

    task automatic run_read(input int idx);
        logic [7:0] b;
        logic [7:0] st;
        setup_transfer(idx, rec_addr[idx]);
        start_transfer(8'hc0 | 8'(rec_cnt[idx]), st);
        if (addr_seen !== {rec_addr[idx][6:0], 1'b1})
            report_mismatch("address byte", {rec_addr[idx][6:0], 1'b1}, addr_seen);
        if (scl_rises != 9 * (rec_cnt[idx] + 1) + 1)
            report_mismatch("SCL pulses", 9 * (rec_cnt[idx] + 1) + 1, scl_rises);
        for (int k = 0; k < rec_cnt[idx]; k++) begin
            apb_read(`I2C_SEL_RX, b);
            if (b !== rec_data[idx][k])
                report_mismatch($sformatf("byte %0d", k), rec_data[idx][k], b);
        end
        apb_read(`I2C_SEL_STATUS, st);
        if (st !== ST_IDLE)
            report_mismatch("status after reads", ST_IDLE, st);
    endtask

    // DUT gets the address in d0, slave answers only to its own
    task automatic run_nack(input int idx);
        logic [7:0] st;
        setup_transfer(idx, rec_data[idx][0]);
        start_transfer(8'hc0 | 8'(rec_cnt[idx]), st);
        if (st !== (ST_IDLE | ST_NACK))
            report_mismatch("status after nack", ST_IDLE | ST_NACK, st);
        if (scl_rises != 9 + 1)  // Address, acknowledge slot and stop only
            report_mismatch("SCL pulses", 10, scl_rises);
    endtask

    initial begin
        int         fd;
        int         c;
        int         cnt;
        int         seed;
        int         errs_before;
        int         limit_sum;
        string      tok;
        string      op;
        logic [7:0] pre;
        logic [7:0] adr;
        logic [7:0] d [4];
        logic [7:0] rd;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        slave_pull = 1'b0;
        in_frame   = 1'b0;
        is_read    = 1'b0;
        addr_ok    = 1'b0;
        master_ack = 1'b0;
        bit_n      = 0;
        byte_n     = 0;
        scl_rises  = 0;
        errors     = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        cycles     = 0;
        n_recs     = 0;
        limit_sum  = 0;
        seed       = 47739;
        seed       = $urandom(seed);  // Fill bytes follow from this seed
        fd = $fopen("bench/i2c_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open pattern file bench/i2c_patterns.txt");
            errors = errors + 1;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[0] == "#") begin
                    c = 0;
                    while (c != 10 && c != -1)
                        c = $fgetc(fd);
                end else if ($fscanf(fd, "%s %h %h %d %h %h %h %h", op, pre, adr, cnt,
                                     d[0], d[1], d[2], d[3]) != 8 || n_recs >= 32) begin
                    $display("Pattern record %s is malformed or one too many", tok);
                    errors = errors + 1;
                end else begin
                    rec_name[n_recs] = tok;
                    rec_op[n_recs]   = op;
                    rec_pre[n_recs]  = pre;
                    rec_addr[n_recs] = adr;
                    rec_cnt[n_recs]  = cnt;
                    for (int k = 0; k < 4; k++)
                        rec_data[n_recs][k] = d[k];
                    limit_sum = limit_sum + (cnt + 2) * 9 * 2 * (int'(pre) + 1);
                    n_recs    = n_recs + 1;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 2 * limit_sum + 1000;
        wait (presetn === 1'b1);

        for (int i = 0; i < n_recs; i++) begin
            cur_name    = rec_name[i];
            errs_before = errors;
            if (rec_op[i] == "status") begin
                apb_read(`I2C_SEL_STATUS, rd);
                if (rd !== rec_data[i][0])
                    report_mismatch("status", rec_data[i][0], rd);
            end else if (rec_op[i] == "regs") begin
                apb_write(`I2C_SEL_PRESCALE, rec_pre[i]);
                apb_write(`I2C_SEL_ADDR, rec_addr[i]);
                apb_read(`I2C_SEL_PRESCALE, rd);
                if (rd !== rec_pre[i])
                    report_mismatch("prescale", rec_pre[i], rd);
                apb_read(`I2C_SEL_ADDR, rd);
                if (rd !== rec_addr[i])
                    report_mismatch("slave address", rec_addr[i], rd);
            end else if (rec_op[i] == "write" || rec_op[i] == "full") begin
                run_write(i);
            end else if (rec_op[i] == "read") begin
                run_read(i);
            end else if (rec_op[i] == "nack") begin
                run_nack(i);
            end else begin
                $display("Test %s has an unknown operation %s", cur_name, rec_op[i]);
                errors = errors + 1;
            end
            if (errors == errs_before) begin
                pass_cnt = pass_cnt + 1;
                $display("Test %s passed", cur_name);
            end else begin
                fail_cnt = fail_cnt + 1;
                $display("Test %s failed", cur_name);
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 n_recs, pass_cnt, fail_cnt, errors);
        if (errors == 0 && n_recs > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== hw/apb_regs.sv ====
`timescale 1ns/1ps
`include "i2c_params.svh"

module apb_regs import i2c_pkg::*; (
    input  logic         PCLK,
    input  logic         PRESETn,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [7:0]   paddr,
    input  i2c_byte_t    pwdata,
    output logic         pready,
    output i2c_byte_t    prdata,
    i2c_fifo_if.producer tx,
    i2c_fifo_if.consumer rx,
    i2c_ctrl_if.regs     ctrl
);

    reg_sel_t  sel;
    logic      access;
    logic      wr_en;
    logic      rd_en;
    i2c_byte_t prescale_reg;
    i2c_byte_t addr_reg;
    i2c_byte_t cmd_reg;
    logic      go_q;
    status_t   status;

    // Decode in the access phase itself
    assign sel    = paddr[7:5];
    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign rd_en  = access && !pwrite;
    assign pready = access;  // No wait states

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            prescale_reg <= '0;
            addr_reg     <= '0;
            cmd_reg      <= '0;
            go_q         <= 1'b0;
        end else begin
            go_q <= 1'b0;
            if (wr_en) begin
                case (sel)
                    `I2C_SEL_PRESCALE: prescale_reg <= pwdata;
                    `I2C_SEL_ADDR:     addr_reg     <= pwdata;
                    `I2C_SEL_CMD: begin
                        cmd_reg <= {1'b0, pwdata[6:0]};  // go bit is not kept
                        go_q    <= pwdata[7];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Engine control
    assign ctrl.go         = go_q;
    assign ctrl.rw         = cmd_reg[6];
    assign ctrl.count      = cmd_reg[3:0];
    assign ctrl.slave_addr = addr_reg[6:0];
    assign ctrl.prescale   = prescale_reg;

    // Transmit writes are dropped when full
    assign tx.push  = wr_en && (sel == `I2C_SEL_TX) && !tx.full;
    assign tx.wdata = pwdata;

    // Receive read consumes the head at the end of the access
    assign rx.pop = rd_en && (sel == `I2C_SEL_RX);

    assign status = {tx.full, tx.empty, rx.full, rx.empty,
                     ctrl.busy, ctrl.nack, 2'b00};

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (sel)
                `I2C_SEL_PRESCALE: prdata = prescale_reg;
                `I2C_SEL_ADDR:     prdata = addr_reg;
                `I2C_SEL_STATUS:   prdata = status;
                `I2C_SEL_RX:       prdata = rx.rdata;
                `I2C_SEL_CMD:      prdata = cmd_reg;
                default:           prdata = '0;  // Transmit is write only
            endcase
        end
    end

endmodule

// ==== hw/byte_fifo.sv ====
`timescale 1ns/1ps
`include "i2c_params.svh"

module byte_fifo import i2c_pkg::*; (
    input  logic       PCLK,
    input  logic       PRESETn,
    i2c_fifo_if.buffer bus
);

    localparam int IDX_W = $clog2(`I2C_FIFO_DEPTH);

    i2c_byte_t   mem [`I2C_FIFO_DEPTH];
    logic [IDX_W-1:0] wr_ptr;
    logic [IDX_W-1:0] rd_ptr;
    fifo_level_t level;
    logic        do_push;
    logic        do_pop;

    assign do_push   = bus.push && !bus.full;
    assign do_pop    = bus.pop && !bus.empty;
    assign bus.full  = (level == fifo_level_t'(`I2C_FIFO_DEPTH));
    assign bus.empty = (level == '0);
    assign bus.rdata = mem[rd_ptr];  // Head always visible

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge PCLK) begin
        if (do_push)
            mem[wr_ptr] <= bus.wdata;
    end

endmodule

// ==== hw/i2c_apb_top.sv ====
`timescale 1ns/1ps

module i2c_apb_top import i2c_pkg::*; (
    input  logic       PCLK,
    input  logic       PRESETn,
    input  logic       PSELx,
    input  logic       PENABLE,
    input  logic       PWRITE,
    input  logic [7:0] PADDR,
    input  i2c_byte_t  PWDATA,
    output logic       PREADY,
    output i2c_byte_t  PRDATA,
    output logic       scl_oe,   // High pulls SCL low
    output logic       sda_oe,   // High pulls SDA low
    input  logic       sda_in
);

    i2c_fifo_if tx_fifo_bus ();
    i2c_fifo_if rx_fifo_bus ();
    i2c_ctrl_if ctrl_bus ();

    apb_regs u_apb_regs (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .psel    (PSELx),
        .penable (PENABLE),
        .pwrite  (PWRITE),
        .paddr   (PADDR),
        .pwdata  (PWDATA),
        .pready  (PREADY),
        .prdata  (PRDATA),
        .tx      (tx_fifo_bus.producer),
        .rx      (rx_fifo_bus.consumer),
        .ctrl    (ctrl_bus.regs)
    );

    // Transmit path buffer
    byte_fifo u_tx_fifo (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .bus     (tx_fifo_bus.buffer)
    );

    // Receive path buffer
    byte_fifo u_rx_fifo (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .bus     (rx_fifo_bus.buffer)
    );

    i2c_byte_engine u_engine (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .ctrl    (ctrl_bus.engine),
        .tx      (tx_fifo_bus.consumer),
        .rx      (rx_fifo_bus.producer),
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

endmodule

// ==== hw/i2c_byte_engine.sv ====
`timescale 1ns/1ps

module i2c_byte_engine import i2c_pkg::*; (
    input  logic         PCLK,
    input  logic         PRESETn,
    i2c_ctrl_if.engine   ctrl,
    i2c_fifo_if.consumer tx,
    i2c_fifo_if.producer rx,
    output logic         scl_oe,
    output logic         sda_oe,
    input  logic         sda_in
);

    eng_state_t  state;
    logic        scl_hi;      // Second half of the bit, SCL released
    i2c_byte_t   div_cnt;
    logic [2:0]  bit_cnt;
    byte_count_t byte_cnt;
    i2c_byte_t   shift;
    logic        rw_q;
    logic        addr_phase;  // Address byte still in flight
    logic        nack_q;
    logic        hold;
    logic        tick;
    logic        start_go;
    logic        load_tx;
    logic        sda_drive;

    // Stall with SCL low until the receive FIFO has room
    assign hold     = (state == ACK_RX) && !scl_hi && rx.full;
    assign tick     = (state != IDLE) && !hold && (div_cnt == ctrl.prescale);
    assign start_go = (state == IDLE) && ctrl.go;

    // Acked byte done, next one comes from the transmit FIFO
    assign load_tx = (state == ACK_TX) && tick && scl_hi && !sda_in
                     && !(rw_q && addr_phase) && !tx.empty;

    assign tx.pop    = load_tx;
    assign rx.push   = (state == ACK_RX) && !scl_hi && tick;
    assign rx.wdata  = shift;
    assign ctrl.busy = (state != IDLE);
    assign ctrl.nack = nack_q;

    assign scl_oe = (state == IDLE || state == START) ? 1'b0 : !scl_hi;

    always_comb begin
        case (state)
            START:   sda_drive = 1'b1;
            SEND:    sda_drive = !shift[7];
            ACK_RX:  sda_drive = (byte_cnt != 4'd1);  // Release on the last byte
            STOP:    sda_drive = 1'b1;
            default: sda_drive = 1'b0;
        endcase
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            state      <= IDLE;
            scl_hi     <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            rw_q       <= 1'b0;
            addr_phase <= 1'b0;
            nack_q     <= 1'b0;
            sda_oe     <= 1'b0;
        end else begin
            sda_oe <= sda_drive;  // One cycle behind SCL
            if (state == IDLE || tick)
                div_cnt <= '0;
            else if (!hold)
                div_cnt <= div_cnt + 1'b1;

            if (start_go) begin
                state      <= START;
                scl_hi     <= 1'b0;
                rw_q       <= ctrl.rw;
                byte_cnt   <= ctrl.count;
                addr_phase <= 1'b1;
                nack_q     <= 1'b0;
            end else if (tick) begin
                scl_hi <= !scl_hi;
                if (scl_hi) begin
                    case (state)
                        START: begin
                            state   <= SEND;
                            bit_cnt <= 3'd7;
                        end
                        SEND: begin
                            if (bit_cnt == 3'd0)
                                state <= ACK_TX;
                            else
                                bit_cnt <= bit_cnt - 1'b1;
                        end
                        RECV: begin
                            if (bit_cnt == 3'd0)
                                state <= ACK_RX;
                            else
                                bit_cnt <= bit_cnt - 1'b1;
                        end
                        ACK_TX: begin
                            addr_phase <= 1'b0;
                            bit_cnt    <= 3'd7;
                            if (sda_in) begin
                                nack_q <= 1'b1;
                                state  <= STOP;
                            end else if (rw_q && addr_phase)
                                state <= RECV;
                            else if (tx.empty)
                                state <= STOP;
                            else
                                state <= SEND;
                        end
                        ACK_RX: begin
                            bit_cnt  <= 3'd7;
                            byte_cnt <= byte_cnt - 1'b1;
                            state    <= (byte_cnt == 4'd1) ? STOP : RECV;
                        end
                        STOP:    state <= IDLE;
                        default: state <= IDLE;
                    endcase
                end
            end
        end
    end

    // Shift register holds the address, a transmit byte or the received byte
    always_ff @(posedge PCLK) begin
        if (start_go)
            shift <= {ctrl.slave_addr, ctrl.rw};
        else if (load_tx)
            shift <= tx.rdata;
        else if (tick && scl_hi && state == SEND && bit_cnt != 3'd0)
            shift <= {shift[6:0], 1'b0};
        else if (tick && scl_hi && state == RECV)
            shift <= {shift[6:0], sda_in};  // Sampled at the end of SCL high
    end

endmodule

// ==== hw/i2c_ctrl_if.sv ====
`timescale 1ns/1ps

interface i2c_ctrl_if import i2c_pkg::*; ();
    logic        go;          // Single-cycle start request
    logic        rw;          // 1 for a read transaction
    byte_count_t count;       // Bytes to read
    logic [6:0]  slave_addr;
    i2c_byte_t   prescale;    // SCL phase length minus one
    logic        busy;
    logic        nack;        // Sticky until next go

    modport regs (
        output go,
        output rw,
        output count,
        output slave_addr,
        output prescale,
        input  busy,
        input  nack
    );

    modport engine (
        input  go,
        input  rw,
        input  count,
        input  slave_addr,
        input  prescale,
        output busy,
        output nack
    );
endinterface

// ==== hw/i2c_fifo_if.sv ====
`timescale 1ns/1ps

interface i2c_fifo_if import i2c_pkg::*; ();
    logic      push;
    i2c_byte_t wdata;
    logic      full;
    logic      pop;
    i2c_byte_t rdata;  // Head entry, valid while not empty
    logic      empty;

    // Writer side, flags go to the status word
    modport producer (output push, output wdata, input full, input empty);

    // Reader side
    modport consumer (output pop, input rdata, input empty, input full);

    // The storage itself
    modport buffer (input push, input wdata, input pop,
                    output full, output rdata, output empty);
endinterface

// ==== hw/i2c_params.svh ====
`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// Data path width
`define I2C_DATA_W 8

// Entries per FIFO, keep to a power of two
`define I2C_FIFO_DEPTH 8

// Register select codes in PADDR[7:5]
`define I2C_SEL_PRESCALE 3'd1
`define I2C_SEL_ADDR     3'd2
`define I2C_SEL_STATUS   3'd3
`define I2C_SEL_TX       3'd4
`define I2C_SEL_RX       3'd5
`define I2C_SEL_CMD      3'd6

`endif

// ==== hw/i2c_pkg.sv ====
`include "i2c_params.svh"

package i2c_pkg;

    // One byte on the bus or in a FIFO
    typedef logic [`I2C_DATA_W-1:0] i2c_byte_t;

    // Register select from PADDR[7:5]
    typedef logic [2:0] reg_sel_t;

    // Bytes to read, 1 to 15
    typedef logic [3:0] byte_count_t;

    // FIFO occupancy, one bit wider than the index
    typedef logic [$clog2(`I2C_FIFO_DEPTH):0] fifo_level_t;

    // tx_full, tx_empty, rx_full, rx_empty, busy, nack, 2'b00
    typedef logic [7:0] status_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        SEND,
        RECV,
        ACK_RX,
        ACK_TX,
        STOP
    } eng_state_t;

endpackage

// ==== src.f ====
+incdir+hw
hw/i2c_pkg.sv
hw/i2c_fifo_if.sv
hw/i2c_ctrl_if.sv
hw/apb_regs.sv
hw/byte_fifo.sv
hw/i2c_byte_engine.sv
hw/i2c_apb_top.sv
bench/tb_clock.sv
bench/tb_i2c_apb.sv
